// ==== cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Memory address width, enough for 64 words
`define CPU_ADDR_W 6

// Word width of memory, registers and instructions
`define CPU_DATA_W 16

// Address of the first instruction after reset
`define CPU_PC_START 8

// Opcode occupies the top four bits of the instruction
`define CPU_OPC_LSB 12

// Each operand field is an address of this width followed by its indirect flag
`define CPU_FIELD_W 3

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef enum logic [3:0] {
        OP_MOV  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_IN   = 4'd7,
        OP_OUT  = 4'd8,
        OP_STOP = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {ST_FETCH, ST_DECODE, ST_EXECUTE, ST_STORE, ST_HALT} state_e;

    // Substates are shared by fetch, operand reads and store
    typedef enum logic [3:0] {
        STEP_LOAD_MAR,
        STEP_IND_WAIT,
        STEP_IND_READ,
        STEP_IND_TO_MAR,
        STEP_WAIT,
        STEP_READ,
        STEP_TO_ACC,
        STEP_TO_MDR,
        STEP_WRITE,
        STEP_SET_STATUS,
        STEP_LOAD_IN
    } step_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_MUL} alu_op_e;
    typedef enum logic [1:0] {MAR_PC, MAR_FIELD, MAR_MDR} mar_src_e;
    typedef enum logic [1:0] {ACC_MDR, ACC_ALU, ACC_IN} acc_src_e;
    typedef enum logic [0:0] {MDR_MEM, MDR_ACC} mdr_src_e;

endpackage

`default_nettype wire

// ==== cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_alu
    import cpu_pkg::*;
(
    input  alu_op_e                alu_op,
    input  logic [`CPU_DATA_W-1:0] a,     // Accumulator, first operand
    input  logic [`CPU_DATA_W-1:0] b,     // MDR, second operand
    output logic [`CPU_DATA_W-1:0] f
);

    // Results wrap modulo 2^16, the product keeps only its low half
    always_comb
    begin
        case (alu_op)
            ALU_ADD:
                f = a + b;
            ALU_SUB:
                f = a - b;
            ALU_MUL:
                f = a * b;
            default:
                f = '0;
        endcase
    end

    always_comb
    begin
        assert (alu_op inside {ALU_ADD, ALU_SUB, ALU_MUL})
        else
            $error("cpu_alu: undefined operation %0d", alu_op);
    end

endmodule

`default_nettype wire

// ==== cpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_datapath
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] mem,
    input  logic [`CPU_DATA_W-1:0] in,
    input  logic                   pc_inc,
    input  logic                   mar_ld,
    input  mar_src_e               mar_sel,
    input  logic [`CPU_FIELD_W-1:0] field_addr,
    input  logic                   mdr_ld,
    input  mdr_src_e               mdr_sel,
    input  logic                   ir_ld,
    input  logic                   acc_ld,
    input  acc_src_e               acc_sel,
    input  alu_op_e                alu_op,
    input  logic                   out_ld,
    input  logic                   we_set,
    output logic [`CPU_DATA_W-1:0] ir,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic [`CPU_DATA_W-1:0] data,
    output logic [`CPU_DATA_W-1:0] out,
    output logic [`CPU_ADDR_W-1:0] pc,
    output logic                   we
);

    logic [`CPU_ADDR_W-1:0] pc_q;
    logic [`CPU_ADDR_W-1:0] mar_q;
    logic [`CPU_DATA_W-1:0] mdr_q;
    logic [`CPU_DATA_W-1:0] ir_q;
    logic [`CPU_DATA_W-1:0] acc_q;
    logic [`CPU_DATA_W-1:0] out_q;
    logic                   we_q;

    logic [`CPU_ADDR_W-1:0] mar_d;
    logic [`CPU_DATA_W-1:0] mdr_d;
    logic [`CPU_DATA_W-1:0] acc_d;
    logic [`CPU_DATA_W-1:0] alu_f;

    cpu_alu i_alu (
        .alu_op (alu_op),
        .a      (acc_q),
        .b      (mdr_q),
        .f      (alu_f)
    );

    always_comb
    begin
        case (mar_sel)
            MAR_FIELD:
                mar_d = {{(`CPU_ADDR_W - `CPU_FIELD_W){1'b0}}, field_addr};
            MAR_MDR:
                mar_d = mdr_q[`CPU_ADDR_W-1:0];   // Pointer word, low 6 bits
            default:
                mar_d = pc_q;
        endcase
    end

    assign mdr_d = (mdr_sel == MDR_ACC) ? acc_q : mem;

    always_comb
    begin
        case (acc_sel)
            ACC_ALU:
                acc_d = alu_f;
            ACC_IN:
                acc_d = in;
            default:
                acc_d = mdr_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc_q  <= `CPU_ADDR_W'(`CPU_PC_START);
            mar_q <= '0;
            mdr_q <= '0;
            ir_q  <= '0;
            acc_q <= '0;
            out_q <= '0;
            we_q  <= 1'b0;
        end
        else
        begin
            if (pc_inc)
                pc_q <= pc_q + `CPU_ADDR_W'(1);
            if (mar_ld)
                mar_q <= mar_d;
            if (mdr_ld)
                mdr_q <= mdr_d;
            if (ir_ld)
                ir_q <= mdr_q;   // Instruction word was read into MDR the cycle before
            if (acc_ld)
                acc_q <= acc_d;
            if (out_ld)
                out_q <= mdr_q;
            we_q <= we_set;      // One-cycle pulse, follows WRITE
        end
    end

    assign ir   = ir_q;
    assign addr = mar_q;
    assign data = mdr_q;
    assign out  = out_q;
    assign pc   = pc_q;
    assign we   = we_q;

    // The memory samples addr in the write cycle, so MAR must not have moved just before it
    assert property (@(posedge clk) disable iff (!rst_n) we |-> !$past(mar_ld))
    else
        $error("cpu_datapath: write issued right after a MAR load");

endmodule

`default_nettype wire

// ==== cpu_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_sequencer
    import cpu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CPU_DATA_W-1:0]  ir,
    output logic                    pc_inc,
    output logic                    mar_ld,
    output mar_src_e                mar_sel,
    output logic [`CPU_FIELD_W-1:0] field_addr,
    output logic                    mdr_ld,
    output mdr_src_e                mdr_sel,
    output logic                    ir_ld,
    output logic                    acc_ld,
    output acc_src_e                acc_sel,
    output alu_op_e                 alu_op,
    output logic                    out_ld,
    output logic                    we_set,
    output logic                    status,
    output logic                    halted
);

    state_e  state_q;
    state_e  state_d;
    step_e   step_q;
    step_e   step_d;
    step_e   cur_step;
    step_e   addr_done;
    logic    z_phase;        // Second operand (Z) of an arithmetic instruction is being read
    logic    z_phase_d;
    opcode_e op;
    logic    op_valid;
    logic    is_arith;
    logic    cur_ind;

    logic [`CPU_FIELD_W-1:0] x_addr;
    logic [`CPU_FIELD_W-1:0] y_addr;
    logic [`CPU_FIELD_W-1:0] z_addr;
    logic                    x_ind;
    logic                    y_ind;
    logic                    z_ind;

    // Fields from low to high are Y, X, Z, each an address with its flag above it
    assign op     = opcode_e'(ir[`CPU_OPC_LSB +: 4]);
    assign y_addr = ir[0 +: `CPU_FIELD_W];
    assign y_ind  = ir[`CPU_FIELD_W];
    assign x_addr = ir[(`CPU_FIELD_W + 1) +: `CPU_FIELD_W];
    assign x_ind  = ir[2 * `CPU_FIELD_W + 1];
    assign z_addr = ir[2 * (`CPU_FIELD_W + 1) +: `CPU_FIELD_W];
    assign z_ind  = ir[3 * `CPU_FIELD_W + 2];

    assign op_valid = op inside {OP_MOV, OP_ADD, OP_SUB, OP_MUL, OP_IN, OP_OUT};
    assign is_arith = op inside {OP_ADD, OP_SUB, OP_MUL};

    always_comb
    begin
        if (state_q == ST_STORE || op == OP_OUT)
        begin
            field_addr = x_addr;
            cur_ind    = x_ind;
        end
        else if (z_phase)
        begin
            field_addr = z_addr;
            cur_ind    = z_ind;
        end
        else
        begin
            field_addr = y_addr;
            cur_ind    = y_ind;
        end
    end

    // IN reads no operand, so its first decode cycle is the status pulse
    assign cur_step = (state_q == ST_DECODE && op == OP_IN && step_q == STEP_LOAD_MAR) ?
                      STEP_SET_STATUS : step_q;

    // Address steps end in a read during decode and in the write during store
    assign addr_done = (state_q == ST_STORE) ? STEP_WRITE : STEP_WAIT;

    always_comb
    begin
        case (op)
            OP_SUB:
                alu_op = ALU_SUB;
            OP_MUL:
                alu_op = ALU_MUL;
            default:
                alu_op = ALU_ADD;
        endcase
    end

    always_comb
    begin
        state_d   = state_q;
        step_d    = step_q;
        z_phase_d = z_phase;
        pc_inc    = 1'b0;
        mar_ld    = 1'b0;
        mar_sel   = MAR_PC;
        mdr_ld    = 1'b0;
        mdr_sel   = MDR_MEM;
        ir_ld     = 1'b0;
        acc_ld    = 1'b0;
        acc_sel   = ACC_MDR;
        out_ld    = 1'b0;
        we_set    = 1'b0;
        case (state_q)
            ST_FETCH:
            begin
                case (step_q)
                    STEP_LOAD_MAR:
                    begin
                        mar_ld = 1'b1;
                        pc_inc = 1'b1;
                        step_d = STEP_WAIT;
                    end
                    STEP_WAIT:
                        step_d = STEP_READ;
                    STEP_READ:
                    begin
                        mdr_ld = 1'b1;
                        step_d = STEP_TO_ACC;
                    end
                    default:
                    begin
                        ir_ld     = 1'b1;
                        z_phase_d = 1'b0;
                        state_d   = ST_DECODE;
                        step_d    = STEP_LOAD_MAR;
                    end
                endcase
            end
            ST_DECODE, ST_STORE:
            begin
                if (state_q == ST_DECODE && !op_valid)
                    state_d = ST_HALT;   // STOP and unknown opcodes
                else
                begin
                    case (cur_step)
                        STEP_LOAD_MAR:
                        begin
                            mar_ld  = 1'b1;
                            mar_sel = MAR_FIELD;
                            step_d  = cur_ind ? STEP_IND_WAIT : addr_done;
                        end
                        STEP_IND_WAIT:
                            step_d = STEP_IND_READ;
                        STEP_IND_READ:
                        begin
                            mdr_ld = 1'b1;
                            step_d = STEP_IND_TO_MAR;
                        end
                        STEP_IND_TO_MAR:
                        begin
                            mar_ld  = 1'b1;
                            mar_sel = MAR_MDR;
                            step_d  = addr_done;
                        end
                        STEP_WAIT:
                            step_d = STEP_READ;
                        STEP_READ:
                        begin
                            mdr_ld = 1'b1;
                            step_d = (op == OP_OUT || z_phase) ? STEP_TO_MDR : STEP_TO_ACC;
                        end
                        STEP_TO_ACC:
                        begin
                            acc_ld = 1'b1;
                            step_d = STEP_LOAD_MAR;
                            if (is_arith)
                                z_phase_d = 1'b1;   // Y is in ACC, go fetch Z
                            else
                                state_d = ST_STORE;
                        end
                        STEP_TO_MDR:
                        begin
                            step_d = STEP_LOAD_MAR;
                            if (op == OP_OUT)
                            begin
                                out_ld  = 1'b1;
                                state_d = ST_FETCH;
                            end
                            else
                                state_d = ST_EXECUTE;   // Z stays in MDR as the ALU operand
                        end
                        STEP_SET_STATUS:
                            step_d = STEP_LOAD_IN;
                        STEP_LOAD_IN:
                        begin
                            acc_ld  = 1'b1;
                            acc_sel = ACC_IN;
                            state_d = ST_STORE;
                            step_d  = STEP_LOAD_MAR;
                        end
                        STEP_WRITE:
                        begin
                            mdr_ld  = 1'b1;
                            mdr_sel = MDR_ACC;
                            we_set  = 1'b1;
                            state_d = ST_FETCH;
                            step_d  = STEP_LOAD_MAR;
                        end
                        default:
                            state_d = ST_HALT;
                    endcase
                end
            end
            ST_EXECUTE:
            begin
                acc_ld  = 1'b1;
                acc_sel = ACC_ALU;
                state_d = ST_STORE;
                step_d  = STEP_LOAD_MAR;
            end
            default:
                state_d = ST_HALT;   // Held until reset
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= ST_FETCH;
            step_q  <= STEP_LOAD_MAR;
            z_phase <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            step_q  <= step_d;
            z_phase <= z_phase_d;
        end
    end

    assign status = (state_q == ST_DECODE) && (cur_step == STEP_SET_STATUS);
    assign halted = (state_q == ST_HALT);

    assert property (@(posedge clk) disable iff (!rst_n) status |=> !status)
    else
        $error("cpu_sequencer: status held longer than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
    else
        $error("cpu_sequencer: left HALT without reset");

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] mem,     // Registered read data for addr
    input  logic [`CPU_DATA_W-1:0] in,
    output logic                   status,
    output logic                   we,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic [`CPU_DATA_W-1:0] data,
    output logic [`CPU_DATA_W-1:0] out,
    output logic [`CPU_ADDR_W-1:0] pc,
    output logic                   halted
);

    logic                    pc_inc;
    logic                    mar_ld;
    mar_src_e                mar_sel;
    logic [`CPU_FIELD_W-1:0] field_addr;
    logic                    mdr_ld;
    mdr_src_e                mdr_sel;
    logic                    ir_ld;
    logic                    acc_ld;
    acc_src_e                acc_sel;
    alu_op_e                 alu_op;
    logic                    out_ld;
    logic                    we_set;
    logic [`CPU_DATA_W-1:0]  ir;

    cpu_sequencer i_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .ir         (ir),
        .pc_inc     (pc_inc),
        .mar_ld     (mar_ld),
        .mar_sel    (mar_sel),
        .field_addr (field_addr),
        .mdr_ld     (mdr_ld),
        .mdr_sel    (mdr_sel),
        .ir_ld      (ir_ld),
        .acc_ld     (acc_ld),
        .acc_sel    (acc_sel),
        .alu_op     (alu_op),
        .out_ld     (out_ld),
        .we_set     (we_set),
        .status     (status),
        .halted     (halted)
    );

    cpu_datapath i_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem        (mem),
        .in         (in),
        .pc_inc     (pc_inc),
        .mar_ld     (mar_ld),
        .mar_sel    (mar_sel),
        .field_addr (field_addr),
        .mdr_ld     (mdr_ld),
        .mdr_sel    (mdr_sel),
        .ir_ld      (ir_ld),
        .acc_ld     (acc_ld),
        .acc_sel    (acc_sel),
        .alu_op     (alu_op),
        .out_ld     (out_ld),
        .we_set     (we_set),
        .ir         (ir),
        .addr       (addr),
        .data       (data),
        .out        (out),
        .pc         (pc),
        .we         (we)
    );

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;

    localparam int NUM_TESTS    = 16;
    localparam int HALT_TIMEOUT = 400;
    localparam int HOLD_CYCLES  = 20;

    localparam logic [3:0] OPC_MOV = 4'h0;
    localparam logic [3:0] OPC_ADD = 4'h1;
    localparam logic [3:0] OPC_SUB = 4'h2;
    localparam logic [3:0] OPC_MUL = 4'h3;
    localparam logic [3:0] OPC_IN  = 4'h7;
    localparam logic [3:0] OPC_OUT = 4'h8;

    localparam logic [15:0] STOP_WORD = 16'hf000;

    logic                   clk;
    logic                   rst_n;
    logic [`CPU_DATA_W-1:0] mem_q;
    logic [`CPU_DATA_W-1:0] in_word;
    logic                   status;
    logic                   we;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] data;
    logic [`CPU_DATA_W-1:0] out_word;
    logic [`CPU_ADDR_W-1:0] pc;
    logic                   halted;

    logic [15:0] image   [64];   // Copied into the memory while reset is low
    logic [15:0] mem_arr [64];
    logic [15:0] exp_img [64];
    int          write_cnt;
    int          status_cnt;

    // Test table with one row per program of one instruction followed by STOP
    logic [15:0]       t_instr [NUM_TESTS];
    logic [0:7][15:0]  t_words [NUM_TESTS];
    logic [15:0]       t_in    [NUM_TESTS];
    logic [15:0]       t_exp   [NUM_TESTS];
    int                n_rows;

    integer seed;
    int     errors;
    int     passed;
    int     failed;
    int     row;

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    cpu_top i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem    (mem_q),
        .in     (in_word),
        .status (status),
        .we     (we),
        .addr   (addr),
        .data   (data),
        .out    (out_word),
        .pc     (pc),
        .halted (halted)
    );

    // Memory with one cycle of read latency that writes on the edge where we is high
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            mem_arr    <= image;
            mem_q      <= '0;
            write_cnt  <= 0;
            status_cnt <= 0;
        end
        else
        begin
            mem_q <= mem_arr[addr];
            if (we)
            begin
                mem_arr[addr] <= data;
                write_cnt     <= write_cnt + 1;
            end
            if (status)
                status_cnt <= status_cnt + 1;
        end
    end

    function automatic logic [15:0] fill_word(input logic [5:0] a);
        return 16'hc300 ^ {a, 2'b01, a, 2'b10};
    endfunction

    function automatic logic [15:0] word_at(input logic [5:0] a, input logic [15:0] instr,
                                            input logic [0:7][15:0] words);
        if (a < 6'(`CPU_PC_START))
            return words[a[2:0]];
        if (a == 6'(`CPU_PC_START))
            return instr;
        if (a == 6'(`CPU_PC_START + 1))
            return STOP_WORD;
        return fill_word(a);
    endfunction

    // Pointer words always sit in 0..7 and only their low 6 bits count
    function automatic logic [5:0] eff_addr(input logic [3:0] fld,
                                            input logic [0:7][15:0] words);
        logic [15:0] ptr;
        ptr = words[fld[2:0]];
        if (fld[3])
            return ptr[5:0];
        return {3'b000, fld[2:0]};
    endfunction

    function automatic logic [15:0] predict(input logic [15:0] instr, input logic [15:0] in_val,
                                            input logic [0:7][15:0] words);
        logic [15:0] y_val;
        logic [15:0] z_val;
        y_val = word_at(eff_addr(instr[3:0], words), instr, words);
        z_val = word_at(eff_addr(instr[11:8], words), instr, words);
        case (instr[15:12])
            OPC_MOV:
                return y_val;
            OPC_ADD:
                return y_val + z_val;
            OPC_SUB:
                return y_val - z_val;
            OPC_MUL:
                return y_val * z_val;
            OPC_IN:
                return in_val;
            default:
                return word_at(eff_addr(instr[7:4], words), instr, words);   // OUT
        endcase
    endfunction

    function automatic string op_name(input logic [3:0] opc);
        case (opc)
            OPC_MOV:
                return "MOV";
            OPC_ADD:
                return "ADD";
            OPC_SUB:
                return "SUB";
            OPC_MUL:
                return "MUL";
            OPC_IN:
                return "IN";
            default:
                return "OUT";
        endcase
    endfunction

    task automatic report_value(input string name, input logic [15:0] got,
                                input logic [15:0] expected);
        $display("[FAIL] %0d ns %s: expected %h, got %h", $time, name, expected, got);
        errors++;
    endtask

    task automatic add_row(input logic [15:0] instr, input logic [15:0] in_val,
                           input logic [0:7][15:0] words);
        t_instr[n_rows] = instr;
        t_words[n_rows] = words;
        t_in[n_rows]    = in_val;
        t_exp[n_rows]   = predict(instr, in_val, words);
        n_rows++;
    endtask

    task automatic random_words(output logic [0:7][15:0] words);
        for (int k = 0; k < 8; k++)
            words[3'(k)] = 16'($random(seed));
    endtask

    task automatic build_table();
        logic [0:7][15:0] rw;
        add_row(16'h0012, 16'h0000, {16'h0a0a, 16'h1111, 16'h2222, 16'h3333,
                                     16'h4444, 16'h5555, 16'h6666, 16'h7777});
        add_row(16'h00cd, 16'h0000, {16'h0a0a, 16'h1111, 16'h2222, 16'h3333,
                                     16'h0002, 16'hffc6, 16'h6666, 16'h7777});
        add_row(16'h003d, 16'h0000, {16'h0a0a, 16'h1111, 16'h2222, 16'h3333,
                                     16'h4444, 16'h0025, 16'h6666, 16'h7777});
        add_row(16'h1102, 16'h0000, {16'h0a0a, 16'h1234, 16'h4321, 16'h3333,
                                     16'h4444, 16'h5555, 16'h6666, 16'h7777});
        add_row(16'h1102, 16'h0000, {16'h0a0a, 16'hffff, 16'h0002, 16'h3333,
                                     16'h4444, 16'h5555, 16'h6666, 16'h7777});
        add_row(16'h2302, 16'h0000, {16'h0a0a, 16'h1111, 16'h0005, 16'h0007,
                                     16'h4444, 16'h5555, 16'h6666, 16'h7777});
        add_row(16'h3412, 16'h0000, {16'h0a0a, 16'h1111, 16'h1234, 16'h3333,
                                     16'h0100, 16'h5555, 16'h6666, 16'h7777});
        add_row(16'h3e52, 16'h0000, {16'h0a0a, 16'h1111, 16'h00ff, 16'h0101,
                                     16'h4444, 16'h5555, 16'h0003, 16'h7777});
        add_row(16'h1dce, 16'h0000, {16'h0a0a, 16'h1111, 16'h2222, 16'h3333,
                                     16'h0001, 16'h0007, 16'h0000, 16'h7777});
        add_row(16'h7050, 16'hbeef, {16'h0a0a, 16'h1111, 16'h2222, 16'h3333,
                                     16'h4444, 16'h5555, 16'h6666, 16'h7777});
        add_row(16'h70f0, 16'h8421, {16'h0a0a, 16'h1111, 16'h2222, 16'h3333,
                                     16'h4444, 16'h5555, 16'h6666, 16'h0021});
        add_row(16'h8030, 16'h0000, {16'h0a0a, 16'h1111, 16'h2222, 16'h3333,
                                     16'h4444, 16'h5555, 16'h6666, 16'h7777});
        add_row(16'h80a0, 16'h0000, {16'h0a0a, 16'h1111, 16'h0030, 16'h3333,
                                     16'h4444, 16'h5555, 16'h6666, 16'h7777});
        random_words(rw);
        add_row(16'h1502, 16'h0000, rw);
        random_words(rw);
        add_row(16'h2634, 16'h0000, rw);
        random_words(rw);
        add_row(16'h3701, 16'h0000, rw);
    endtask

    task automatic check_idle();
        if (we !== 1'b0)
            report_value("we", 16'(we), 16'h0000);
        if (status !== 1'b0)
            report_value("status", 16'(status), 16'h0000);
        if (halted !== 1'b0)
            report_value("halted", 16'(halted), 16'h0000);
        if (out_word !== 16'h0000)
            report_value("out", out_word, 16'h0000);
        if (pc !== 6'(`CPU_PC_START))
            report_value("pc", 16'(pc), 16'(`CPU_PC_START));
    endtask

    task automatic apply_reset(input logic [15:0] in_val);
        @(posedge clk);
        #2;
        rst_n   = 1'b0;
        in_word = in_val;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();   // First cycle out of reset
    endtask

    task automatic run_test(input int i);
        logic [15:0] instr;
        logic [5:0]  ea_x;
        logic [5:0]  pc_halt;
        logic        is_out;
        logic        hold_ok;
        int          cycles;
        int          errs_before;
        errs_before = errors;
        instr  = t_instr[i];
        is_out = (instr[15:12] == OPC_OUT);
        ea_x   = eff_addr(instr[7:4], t_words[i]);
        for (int a = 0; a < 64; a++)
        begin
            image[6'(a)]   = word_at(6'(a), instr, t_words[i]);
            exp_img[6'(a)] = image[6'(a)];
        end
        if (!is_out)
            exp_img[ea_x] = t_exp[i];
        apply_reset(t_in[i]);
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!halted)
        begin
            $display("test %0d: timeout, halted did not rise within %0d cycles", i, HALT_TIMEOUT);
            errors++;
        end
        else
        begin
            pc_halt = pc;
            hold_ok = 1'b1;
            for (cycles = 0; cycles < HOLD_CYCLES; cycles++)
            begin
                @(negedge clk);
                if (!halted)
                    hold_ok = 1'b0;
            end
            if (!hold_ok)
            begin
                $display("test %0d: halted dropped while the CPU should stay stopped", i);
                errors++;
            end
            if (pc !== pc_halt)
                report_value("pc", 16'(pc), 16'(pc_halt));
            if (pc !== 6'(`CPU_PC_START + 2))   // Two fetches of the instruction and STOP
                report_value("pc", 16'(pc), 16'(`CPU_PC_START + 2));
            for (int a = 0; a < 64; a++)
                if (mem_arr[6'(a)] !== exp_img[6'(a)])
                    report_value($sformatf("mem[%0d]", a), mem_arr[6'(a)], exp_img[6'(a)]);
            if (out_word !== (is_out ? t_exp[i] : 16'h0000))
                report_value("out", out_word, is_out ? t_exp[i] : 16'h0000);
            if (write_cnt != (is_out ? 0 : 1))
                report_value("write count", 16'(write_cnt), is_out ? 16'h0000 : 16'h0001);
            if (status_cnt != ((instr[15:12] == OPC_IN) ? 1 : 0))
                report_value("status cycles", 16'(status_cnt),
                             (instr[15:12] == OPC_IN) ? 16'h0001 : 16'h0000);
        end
        if (errors == errs_before)
        begin
            passed++;
            $display("test %0d %s %h: ok", i, op_name(instr[15:12]), instr);
        end
        else
        begin
            failed++;
            $display("test %0d %s %h: mismatch", i, op_name(instr[15:12]), instr);
        end
    endtask

    initial
    begin
        rst_n   = 1'b0;
        in_word = '0;
        seed    = 97015;
        errors  = 0;
        passed  = 0;
        failed  = 0;
        n_rows  = 0;
        build_table();
        for (row = 0; row < n_rows; row++)
            run_test(row);
        $display("%0d tests, %0d passed, %0d failed, %0d errors", n_rows, passed, failed, errors);
        if (failed == 0 && errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_datapath.sv
cpu_sequencer.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the accumulator CPU

BUILD = obj_dir
LOG   = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
		--top-module tb_cpu --Mdir $(BUILD) -o tb_cpu
	./$(BUILD)/tb_cpu | tee $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sim.f --top-module tb_cpu

clean:
	rm -rf $(BUILD) $(LOG)
